//--- files.f
icache_pkg.sv
icache_fill_if.sv
icache_ctrl.sv
icache_tag_array.sv
icache_data_array.sv
icache_lru.sv
icache_top.sv
icache_chk.sv
tb_icache.sv

//--- icache_chk.sv
// fetch control assertions
`timescale 1ns/10ps
`default_nettype none

module icache_chk import icache_pkg::*; (
  input logic clk_i,
  input logic reset_i,
  input logic data_v_i,
  input logic cache_req_v_i,
  input logic cache_req_ready_i,
  input logic vaddr_ready_i,
  input pipe_state_e state_i
);

  int fail_cnt = 0;

  // a fetch gives data or a request but never both
  a_one_result: assert property (@(posedge clk_i) disable iff (reset_i)
    !(data_v_i && cache_req_v_i))
    else begin
      fail_cnt++;
      $error("hit data and miss request in the same cycle");
    end

  a_req_ready: assert property (@(posedge clk_i) disable iff (reset_i)
    cache_req_v_i |-> cache_req_ready_i)
    else begin
      fail_cnt++;
      $error("miss request raised while request ready is low");
    end

  a_no_fetch_in_miss: assert property (@(posedge clk_i) disable iff (reset_i)
    (state_i == pipe_wait_fill) |-> !vaddr_ready_i)
    else begin
      fail_cnt++;
      $error("fetch ready high during a miss");
    end

endmodule

bind icache_ctrl icache_chk icache_chk_i (
  .clk_i(clk_i),
  .reset_i(reset_i),
  .data_v_i(data_v_o),
  .cache_req_v_i(cache_req_v_o),
  .cache_req_ready_i(cache_req_ready_i),
  .vaddr_ready_i(vaddr_ready_o),
  .state_i(state_r)
);

`default_nettype wire

//--- icache_ctrl.sv
// icache fetch pipeline control
`timescale 1ns/10ps
`default_nettype none

module icache_ctrl import icache_pkg::*; (
  input  logic clk_i,
  input  logic reset_i,

  input  vaddr_t vaddr_i,
  input  logic vaddr_v_i,
  output logic vaddr_ready_o,

  input  ptag_t ptag_i,
  input  logic ptag_v_i,

  output logic data_v_o,
  output logic miss_o,

  output logic cache_req_v_o,
  input  logic cache_req_ready_i,
  output paddr_t cache_req_addr_o,
  input  logic cache_req_complete_i,

  output logic fill_ready_o,
  input  logic data_fill_v_i,
  input  logic tag_fill_v_i,

  input  logic hit_i,
  output logic lookup_en_o,
  output index_t lookup_index_o,
  output logic tv_en_o,
  output logic hit_update_o,

  icache_fill_if.ctrl fill
);

  logic tl_we;
  logic miss_tv;
  logic tv_hold;
  logic v_tl_r;
  logic v_tv_r;
  logic [page_off_w-1:0] page_off_tl_r;
  paddr_t addr_tv_r;
  pipe_state_e state_r;
  pipe_state_e state_n;

  assign miss_o = (state_r == pipe_wait_fill);
  assign vaddr_ready_o = cache_req_ready_i & ~miss_o & ~cache_req_v_o;
  assign tl_we = vaddr_v_i & vaddr_ready_o;

  assign lookup_en_o = tl_we;
  assign lookup_index_o = vaddr_i[block_off_w +: index_w];

  // lookups win over fills
  assign fill_ready_o = ~tl_we;
  assign fill.tag_we = tag_fill_v_i & fill_ready_o;
  assign fill.data_we = data_fill_v_i & fill_ready_o;

  assign miss_tv = v_tv_r & ~hit_i;
  assign tv_hold = miss_tv & ~cache_req_ready_i;

  // a miss in TV squashes whatever sits in TL
  assign tv_en_o = v_tl_r & ptag_v_i & ~miss_tv;

  assign data_v_o = v_tv_r & hit_i;
  assign hit_update_o = data_v_o;
  assign cache_req_v_o = miss_tv & cache_req_ready_i;
  assign cache_req_addr_o = addr_tv_r;

  always_comb begin
    state_n = state_r;
    case (state_r)
      pipe_run: begin
        if (cache_req_v_o) begin
          state_n = pipe_wait_fill;
        end
      end
      pipe_wait_fill: begin
        if (cache_req_complete_i) begin
          state_n = pipe_run;
        end
      end
      default: state_n = pipe_run;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      v_tl_r <= 1'b0;
      v_tv_r <= 1'b0;
      state_r <= pipe_run;
    end else begin
      v_tl_r <= tl_we;
      v_tv_r <= tv_en_o | tv_hold;
      state_r <= state_n;
    end
  end

  always_ff @(posedge clk_i) begin
    if (tl_we) begin
      page_off_tl_r <= vaddr_i[page_off_w-1:0];
    end
    if (tv_en_o) begin
      addr_tv_r <= {ptag_i, page_off_tl_r};
    end
  end

endmodule

`default_nettype wire

//--- icache_data_array.sv
// icache block data array
`timescale 1ns/10ps
`default_nettype none

module icache_data_array import icache_pkg::*; #(
  parameter int sets_p = icache_sets,
  parameter int ways_p = icache_ways
) (
  input  logic clk_i,
  input  logic lookup_en_i,
  input  index_t lookup_index_i,
  input  logic tv_en_i,
  input  way_t hit_way_i,
  input  logic [word_sel_w-1:0] word_sel_i,
  icache_fill_if.array fill,
  output instr_t data_o
);

  block_t tv_blk [ways_p];
  block_t blk_sel;

  // one array per way, whole-block writes
  for (genvar w = 0; w < ways_p; w++) begin : g_way
    block_t mem [sets_p];
    block_t rd_r;
    block_t tv_r;

    always_ff @(posedge clk_i) begin
      if (fill.data_we && (fill.way == way_t'(w))) begin
        mem[fill.index] <= fill.data;
      end
      if (lookup_en_i) begin
        rd_r <= mem[lookup_index_i];
      end
      if (tv_en_i) begin
        tv_r <= rd_r;
      end
    end

    assign tv_blk[w] = tv_r;
  end

  // way select, then word within the block
  assign blk_sel = tv_blk[hit_way_i];
  assign data_o = blk_sel[word_sel_i*instr_w +: instr_w];

endmodule

`default_nettype wire

//--- icache_fill_if.sv
// icache fill bus
`timescale 1ns/10ps
`default_nettype none

interface icache_fill_if import icache_pkg::*; ();

  logic tag_we;
  tag_op_e tag_op;
  logic data_we;
  index_t index;
  way_t way;
  tag_t tag;
  block_t data;

  // write strobes come from the control
  modport ctrl (
    output tag_we,
    output data_we
  );

  modport array (
    input tag_we,
    input tag_op,
    input data_we,
    input index,
    input way,
    input tag,
    input data
  );

endinterface

`default_nettype wire

//--- icache_lru.sv
// icache pseudo-LRU state
`timescale 1ns/10ps
`default_nettype none

module icache_lru import icache_pkg::*; #(
  parameter int sets_p = icache_sets,
  parameter int ways_p = icache_ways
) (
  input  logic clk_i,
  input  logic reset_i,
  input  logic lookup_en_i,
  input  index_t lookup_index_i,
  input  logic tv_en_i,
  input  logic hit_update_i,
  input  way_t hit_way_i,
  input  logic invalid_exist_i,
  input  way_t invalid_way_i,
  icache_fill_if.array fill,
  output way_t victim_way_o
);

  if (ways_p != 4) begin : g_ways_chk
    $error("icache_lru: tree logic needs exactly 4 ways");
  end

  lru_t lru_r [sets_p];
  index_t idx_tl_r;
  index_t idx_tv_r;
  lru_t lru_tl;
  lru_t lru_tv_r;
  lru_t lru_upd;
  way_t tree_way;
  logic clear_v;

  assign clear_v = fill.tag_we & (fill.tag_op == tag_clear_set);

  // TL read sees this cycle's writes to the same set
  always_comb begin
    if (clear_v && (fill.index == idx_tl_r)) begin
      lru_tl = '0;
    end else if (hit_update_i && (idx_tv_r == idx_tl_r)) begin
      lru_tl = lru_upd;
    end else begin
      lru_tl = lru_r[idx_tl_r];
    end
  end

  // point away from the hit way
  always_comb begin
    lru_upd = lru_tv_r;
    lru_upd[0] = ~hit_way_i[1];
    if (hit_way_i[1]) begin
      lru_upd[2] = ~hit_way_i[0];
    end else begin
      lru_upd[1] = ~hit_way_i[0];
    end
  end

  assign tree_way = lru_tv_r[0] ? {1'b1, lru_tv_r[2]} : {1'b0, lru_tv_r[1]};
  assign victim_way_o = invalid_exist_i ? invalid_way_i : tree_way;

  always_ff @(posedge clk_i) begin
    if (lookup_en_i) begin
      idx_tl_r <= lookup_index_i;
    end
    if (tv_en_i) begin
      idx_tv_r <= idx_tl_r;
      lru_tv_r <= lru_tl;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int s = 0; s < sets_p; s++) begin
        lru_r[s] <= '0;
      end
    end else begin
      if (hit_update_i) begin
        lru_r[idx_tv_r] <= lru_upd;
      end
      // set clear overrides a same-cycle hit update
      if (clear_v) begin
        lru_r[fill.index] <= '0;
      end
    end
  end

endmodule

`default_nettype wire

//--- icache_pkg.sv
// icache shared types
`default_nettype none

package icache_pkg;

  // geometry
  localparam int icache_sets = 64;
  localparam int icache_ways = 4;

  localparam int vaddr_w = 32;
  localparam int paddr_w = 32;
  localparam int instr_w = 32;
  localparam int block_words = 8;
  localparam int word_sel_w = $clog2(block_words);
  localparam int word_lsb = 2;
  localparam int block_off_w = 5;
  localparam int page_off_w = 12;
  localparam int index_w = $clog2(icache_sets);
  localparam int tag_lsb = block_off_w + index_w;
  localparam int tag_w = paddr_w - tag_lsb;
  localparam int ptag_w = paddr_w - page_off_w;
  localparam int way_w = $clog2(icache_ways);

  typedef logic [vaddr_w-1:0] vaddr_t;
  typedef logic [paddr_w-1:0] paddr_t;
  typedef logic [ptag_w-1:0] ptag_t;
  typedef logic [tag_w-1:0] tag_t;
  typedef logic [index_w-1:0] index_t;
  typedef logic [way_w-1:0] way_t;
  typedef logic [instr_w-1:0] instr_t;
  typedef logic [block_words*instr_w-1:0] block_t;
  typedef logic [icache_ways-2:0] lru_t;

  typedef enum logic [1:0] {
    tag_set = 2'd0,
    tag_invalidate = 2'd1,
    tag_clear_set = 2'd2
  } tag_op_e;

  typedef enum logic {
    pipe_run,
    pipe_wait_fill
  } pipe_state_e;

endpackage

`default_nettype wire

//--- icache_tag_array.sv
// icache tag and valid array
`timescale 1ns/10ps
`default_nettype none

module icache_tag_array import icache_pkg::*; #(
  parameter int sets_p = icache_sets,
  parameter int ways_p = icache_ways
) (
  input  logic clk_i,
  input  logic reset_i,
  input  logic lookup_en_i,
  input  index_t lookup_index_i,
  input  logic tv_en_i,
  input  tag_t addr_tag_i,
  icache_fill_if.array fill,
  output logic hit_o,
  output way_t hit_way_o,
  output logic invalid_exist_o,
  output way_t invalid_way_o
);

  logic [ways_p-1:0] valid_r [sets_p];
  logic [ways_p-1:0] valid_tl_r;
  logic [ways_p-1:0] valid_tv_r;
  logic [ways_p-1:0] way_sel;
  logic [ways_p-1:0] tag_wr;
  logic [ways_p-1:0] valid_wr;
  logic valid_val;
  logic [ways_p-1:0] hit_vec;

  // per-way write masks for the tag ops
  always_comb begin
    way_sel = '0;
    way_sel[fill.way] = 1'b1;
    tag_wr = '0;
    valid_wr = '0;
    valid_val = 1'b0;
    case (fill.tag_op)
      tag_set: begin
        tag_wr = way_sel;
        valid_wr = way_sel;
        valid_val = 1'b1;
      end
      tag_invalidate: valid_wr = way_sel;
      tag_clear_set: valid_wr = '1;
      default: valid_wr = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int s = 0; s < sets_p; s++) begin
        valid_r[s] <= '0;
      end
    end else if (fill.tag_we) begin
      for (int w = 0; w < ways_p; w++) begin
        if (valid_wr[w]) begin
          valid_r[fill.index][w] <= valid_val;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (lookup_en_i) begin
      valid_tl_r <= valid_r[lookup_index_i];
    end
    if (tv_en_i) begin
      valid_tv_r <= valid_tl_r;
    end
  end

  for (genvar w = 0; w < ways_p; w++) begin : g_way
    tag_t mem [sets_p];
    tag_t rd_r;
    tag_t tv_r;

    always_ff @(posedge clk_i) begin
      if (fill.tag_we && tag_wr[w]) begin
        mem[fill.index] <= fill.tag;
      end
      if (lookup_en_i) begin
        rd_r <= mem[lookup_index_i];
      end
      if (tv_en_i) begin
        tv_r <= rd_r;
      end
    end

    assign hit_vec[w] = valid_tv_r[w] & (tv_r == addr_tag_i);
  end

  assign hit_o = |hit_vec;
  assign invalid_exist_o = ~&valid_tv_r;

  // lowest way wins on both encoders
  always_comb begin
    hit_way_o = '0;
    invalid_way_o = '0;
    for (int w = ways_p - 1; w >= 0; w--) begin
      if (hit_vec[w]) begin
        hit_way_o = way_t'(w);
      end
      if (!valid_tv_r[w]) begin
        invalid_way_o = way_t'(w);
      end
    end
  end

endmodule

`default_nettype wire

//--- icache_top.sv
// icache top level
`timescale 1ns/10ps
`default_nettype none

module icache_top import icache_pkg::*; #(
  parameter int sets_p = icache_sets,
  parameter int ways_p = icache_ways
) (
  input  logic clk_i,
  input  logic reset_i,

  input  vaddr_t vaddr_i,
  input  logic vaddr_v_i,
  output logic vaddr_ready_o,

  input  ptag_t ptag_i,
  input  logic ptag_v_i,

  output instr_t data_o,
  output logic data_v_o,
  output logic miss_o,

  output logic cache_req_v_o,
  input  logic cache_req_ready_i,
  output paddr_t cache_req_addr_o,
  output way_t cache_req_way_o,
  input  logic cache_req_complete_i,

  output logic fill_ready_o,
  input  logic data_fill_v_i,
  input  logic tag_fill_v_i,
  input  index_t fill_index_i,
  input  way_t fill_way_i,
  input  tag_t fill_tag_i,
  input  tag_op_e fill_op_i,
  input  block_t fill_data_i
);

  logic lookup_en;
  index_t lookup_index;
  logic tv_en;
  logic hit_update;
  logic hit;
  way_t hit_way;
  logic invalid_exist;
  way_t invalid_way;

  icache_fill_if fill ();

  assign fill.index = fill_index_i;
  assign fill.way = fill_way_i;
  assign fill.tag = fill_tag_i;
  assign fill.tag_op = fill_op_i;
  assign fill.data = fill_data_i;

  icache_ctrl icache_ctrl_i (
    .clk_i(clk_i),
    .reset_i(reset_i),
    .vaddr_i(vaddr_i),
    .vaddr_v_i(vaddr_v_i),
    .vaddr_ready_o(vaddr_ready_o),
    .ptag_i(ptag_i),
    .ptag_v_i(ptag_v_i),
    .data_v_o(data_v_o),
    .miss_o(miss_o),
    .cache_req_v_o(cache_req_v_o),
    .cache_req_ready_i(cache_req_ready_i),
    .cache_req_addr_o(cache_req_addr_o),
    .cache_req_complete_i(cache_req_complete_i),
    .fill_ready_o(fill_ready_o),
    .data_fill_v_i(data_fill_v_i),
    .tag_fill_v_i(tag_fill_v_i),
    .hit_i(hit),
    .lookup_en_o(lookup_en),
    .lookup_index_o(lookup_index),
    .tv_en_o(tv_en),
    .hit_update_o(hit_update),
    .fill(fill.ctrl)
  );

  // TV physical address supplies the compare tag and word select
  icache_tag_array #(.sets_p(sets_p), .ways_p(ways_p)) icache_tag_array_i (
    .clk_i(clk_i),
    .reset_i(reset_i),
    .lookup_en_i(lookup_en),
    .lookup_index_i(lookup_index),
    .tv_en_i(tv_en),
    .addr_tag_i(cache_req_addr_o[tag_lsb +: tag_w]),
    .fill(fill.array),
    .hit_o(hit),
    .hit_way_o(hit_way),
    .invalid_exist_o(invalid_exist),
    .invalid_way_o(invalid_way)
  );

  icache_data_array #(.sets_p(sets_p), .ways_p(ways_p)) icache_data_array_i (
    .clk_i(clk_i),
    .lookup_en_i(lookup_en),
    .lookup_index_i(lookup_index),
    .tv_en_i(tv_en),
    .hit_way_i(hit_way),
    .word_sel_i(cache_req_addr_o[word_lsb +: word_sel_w]),
    .fill(fill.array),
    .data_o(data_o)
  );

  icache_lru #(.sets_p(sets_p), .ways_p(ways_p)) icache_lru_i (
    .clk_i(clk_i),
    .reset_i(reset_i),
    .lookup_en_i(lookup_en),
    .lookup_index_i(lookup_index),
    .tv_en_i(tv_en),
    .hit_update_i(hit_update),
    .hit_way_i(hit_way),
    .invalid_exist_i(invalid_exist),
    .invalid_way_i(invalid_way),
    .fill(fill.array),
    .victim_way_o(cache_req_way_o)
  );

endmodule

`default_nettype wire

//--- tb_icache.sv
// icache testbench
`timescale 1ns/10ps
`default_nettype none

module tb_icache import icache_pkg::*; ();

  localparam int wait_limit = 64;

  logic clk_i;
  logic reset_i;
  vaddr_t vaddr_i;
  logic vaddr_v_i;
  logic vaddr_ready_o;
  ptag_t ptag_i;
  logic ptag_v_i;
  instr_t data_o;
  logic data_v_o;
  logic miss_o;
  logic cache_req_v_o;
  logic cache_req_ready_i;
  paddr_t cache_req_addr_o;
  way_t cache_req_way_o;
  logic cache_req_complete_i;
  logic fill_ready_o;
  logic data_fill_v_i;
  logic tag_fill_v_i;
  index_t fill_index_i;
  way_t fill_way_i;
  tag_t fill_tag_i;
  tag_op_e fill_op_i;
  block_t fill_data_i;

  // reference model of the cache contents
  tag_t model_tag [64][4];
  logic [3:0] model_valid [64];
  lru_t model_lru [64];
  block_t model_blk [64][4];

  // pending fetch list and expected results
  paddr_t fq_pa [$];
  logic fq_pv [$];
  logic fq_exp [$];
  paddr_t exp_pa [$];
  int exp_due [$];

  logic [31:0] lfsr_r;
  int cycle_cnt;
  int errors;
  string test_name;

  icache_top icache_top_i (.*);

  always #50 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
  endfunction

  task automatic rand_bits(input int n, output block_t v);
    int i;
    v = '0;
    for (i = 0; i < n; i++) begin
      v[i] = lfsr_r[0];
      lfsr_r = lfsr_next(lfsr_r);
    end
  endtask

  task automatic new_tag(output tag_t t);
    block_t v;
    rand_bits(21, v);
    t = v[20:0];
  endtask

  function automatic paddr_t make_paddr(tag_t t, index_t s, logic [2:0] word);
    return {t, s, word, 2'b00};
  endfunction

  // expected hit and instruction, or miss with its replacement way
  function automatic logic expect_fetch(input paddr_t pa, output instr_t instr,
                                        output way_t way);
    index_t s;
    tag_t t;
    logic hit;
    lru_t l;
    block_t b;
    int w;
    s = pa[10:5];
    t = pa[31:11];
    hit = 1'b0;
    way = '0;
    for (w = 3; w >= 0; w--) begin
      if (model_valid[s][w] && model_tag[s][w] == t) begin
        hit = 1'b1;
        way = way_t'(w);
      end
    end
    if (!hit) begin
      if (model_valid[s] != 4'hf) begin
        for (w = 3; w >= 0; w--) begin
          if (!model_valid[s][w]) begin
            way = way_t'(w);
          end
        end
      end else begin
        l = model_lru[s];
        // follow the tree from the root bit
        if (!l[0]) begin
          way = l[1] ? 2'd1 : 2'd0;
        end else begin
          way = l[2] ? 2'd3 : 2'd2;
        end
      end
    end
    b = model_blk[s][way];
    instr = b[pa[4:2]*32 +: 32];
    return hit;
  endfunction

  // tree bits point away from the way just used
  function automatic void update_lru(index_t s, way_t w);
    case (w)
      2'd0: begin
        model_lru[s][0] = 1'b1;
        model_lru[s][1] = 1'b1;
      end
      2'd1: begin
        model_lru[s][0] = 1'b1;
        model_lru[s][1] = 1'b0;
      end
      2'd2: begin
        model_lru[s][0] = 1'b0;
        model_lru[s][2] = 1'b1;
      end
      default: begin
        model_lru[s][0] = 1'b0;
        model_lru[s][2] = 1'b0;
      end
    endcase
  endfunction

  task automatic fail_now(string msg);
    $display("%s", msg);
    $display("test failed");
    $fatal(1);
  endtask

  task automatic check_instr(string what, instr_t exp, instr_t act);
    if (exp !== act) begin
      fail_now($sformatf("** Error %s %s: expected %h, got %h", test_name, what, exp, act));
    end
  endtask

  task automatic check_addr(string what, paddr_t exp, paddr_t act);
    if (exp !== act) begin
      fail_now($sformatf("** Error %s %s: expected %h, got %h", test_name, what, exp, act));
    end
  endtask

  task automatic check_way(string what, way_t exp, way_t act);
    if (exp !== act) begin
      fail_now($sformatf("** Error %s %s: expected %0d, got %0d", test_name, what, exp, act));
    end
  endtask

  task automatic check_flag(string what, logic exp, logic act);
    if (exp !== act) begin
      fail_now($sformatf("** Error %s %s: expected %b, got %b", test_name, what, exp, act));
    end
  endtask

  task automatic compare_cycle();
    paddr_t pa;
    int due;
    logic hit;
    instr_t instr;
    way_t way;
    if (icache_top_i.icache_ctrl_i.icache_chk_i.fail_cnt != 0) begin
      fail_now("an assertion on the fetch control failed");
    end
    if (data_v_o || cache_req_v_o) begin
      if (exp_pa.size() == 0) begin
        fail_now($sformatf("%s: the cache gave a result with no fetch pending", test_name));
      end
      pa = exp_pa.pop_front();
      due = exp_due.pop_front();
      if (due >= 0 && due != cycle_cnt) begin
        fail_now($sformatf("** Error %s result cycle: expected %0d, got %0d",
                           test_name, due, cycle_cnt));
      end
      hit = expect_fetch(pa, instr, way);
      check_flag("hit", hit, data_v_o);
      check_flag("request", ~hit, cache_req_v_o);
      if (hit) begin
        check_instr("instruction", instr, data_o);
        update_lru(pa[10:5], way);
      end else begin
        check_addr("request address", pa, cache_req_addr_o);
        check_way("request way", way, cache_req_way_o);
      end
    end else if (exp_pa.size() != 0 && exp_due[0] >= 0 && exp_due[0] <= cycle_cnt) begin
      fail_now($sformatf("%s: no result arrived for fetch %h", test_name, exp_pa[0]));
    end
  endtask

  always @(negedge clk_i) begin
    if (!reset_i) begin
      compare_cycle();
    end
  end

  task automatic wait_ready();
    int n;
    n = 0;
    @(posedge clk_i);
    #1;
    while (!vaddr_ready_o) begin
      n++;
      if (n > wait_limit) begin
        fail_now("timeout: fetch ready never came back");
      end
      @(posedge clk_i);
      #1;
    end
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while (exp_pa.size() != 0) begin
      n++;
      if (n > wait_limit) begin
        fail_now("timeout: an expected fetch result never arrived");
      end
      @(posedge clk_i);
      #1;
    end
  endtask

  task automatic add_fetch(paddr_t pa, logic pv, logic exp);
    fq_pa.push_back(pa);
    fq_pv.push_back(pv);
    fq_exp.push_back(exp);
  endtask

  // back-to-back fetches with each page tag one cycle behind its address
  task automatic run_fetches();
    int n;
    int i;
    n = fq_pa.size();
    wait_ready();
    for (i = 0; i <= n; i++) begin
      vaddr_v_i = (i < n);
      if (i < n) begin
        vaddr_i = {~fq_pa[i][31:12], fq_pa[i][11:0]};
        if (fq_exp[i]) begin
          exp_pa.push_back(fq_pa[i]);
          exp_due.push_back(cycle_cnt + 2);
        end
      end
      ptag_v_i = (i > 0) ? fq_pv[i-1] : 1'b0;
      if (i > 0) begin
        ptag_i = fq_pa[i-1][31:12];
      end
      @(posedge clk_i);
      #1;
    end
    ptag_v_i = 1'b0;
    fq_pa.delete();
    fq_pv.delete();
    fq_exp.delete();
  endtask

  task automatic write_tag(index_t s, way_t w, tag_op_e op, tag_t t);
    @(posedge clk_i);
    #1;
    fill_index_i = s;
    fill_way_i = w;
    fill_op_i = op;
    fill_tag_i = t;
    tag_fill_v_i = 1'b1;
    @(negedge clk_i);
    check_flag("fill ready", 1'b1, fill_ready_o);
    @(posedge clk_i);
    #1;
    tag_fill_v_i = 1'b0;
    case (op)
      tag_set: begin
        model_tag[s][w] = t;
        model_valid[s][w] = 1'b1;
      end
      tag_invalidate: model_valid[s][w] = 1'b0;
      tag_clear_set: begin
        model_valid[s] = '0;
        model_lru[s] = '0;
      end
      default: ;
    endcase
  endtask

  task automatic write_block(index_t s, way_t w, block_t blk);
    @(posedge clk_i);
    #1;
    fill_index_i = s;
    fill_way_i = w;
    fill_data_i = blk;
    data_fill_v_i = 1'b1;
    @(negedge clk_i);
    check_flag("fill ready", 1'b1, fill_ready_o);
    @(posedge clk_i);
    #1;
    data_fill_v_i = 1'b0;
    model_blk[s][w] = blk;
  endtask

  task automatic complete_miss();
    check_flag("miss held", 1'b1, miss_o);
    @(posedge clk_i);
    #1;
    cache_req_complete_i = 1'b1;
    @(posedge clk_i);
    #1;
    cache_req_complete_i = 1'b0;
    check_flag("miss cleared", 1'b0, miss_o);
  endtask

  // refill the way the request named, then finish the miss
  task automatic service_miss(paddr_t pa);
    instr_t instr;
    way_t way;
    block_t blk;
    void'(expect_fetch(pa, instr, way));
    rand_bits(256, blk);
    write_tag(pa[10:5], way, tag_set, pa[31:11]);
    write_block(pa[10:5], way, blk);
    complete_miss();
  endtask

  initial begin
    paddr_t pa_hit;
    paddr_t pa;
    tag_t t;
    tag_t set_tags [4];
    block_t blk;
    int w;
    clk_i = 1'b0;
    reset_i = 1'b1;
    vaddr_i = '0;
    vaddr_v_i = 1'b0;
    ptag_i = '0;
    ptag_v_i = 1'b0;
    cache_req_ready_i = 1'b1;
    cache_req_complete_i = 1'b0;
    data_fill_v_i = 1'b0;
    tag_fill_v_i = 1'b0;
    fill_index_i = '0;
    fill_way_i = '0;
    fill_tag_i = '0;
    fill_op_i = tag_set;
    fill_data_i = '0;
    lfsr_r = 32'd60;
    cycle_cnt = 0;
    test_name = "reset";
    for (w = 0; w < 64; w++) begin
      model_valid[w] = '0;
      model_lru[w] = '0;
    end
    repeat (8) @(posedge clk_i);
    #1;
    reset_i = 1'b0;
    check_flag("miss after reset", 1'b0, miss_o);

    test_name = "cold_miss";
    new_tag(t);
    pa_hit = make_paddr(t, 6'd5, 3'd3);
    add_fetch(pa_hit, 1'b1, 1'b1);
    run_fetches();
    wait_drain();
    repeat (3) begin
      check_flag("miss pending", 1'b1, miss_o);
      @(posedge clk_i);
      #1;
    end
    service_miss(pa_hit);

    test_name = "hit_after_fill";
    for (w = 0; w < 8; w++) begin
      add_fetch(make_paddr(t, 6'd5, w[2:0]), 1'b1, 1'b1);
    end
    run_fetches();
    wait_drain();

    test_name = "victim";
    for (w = 0; w < 4; w++) begin
      new_tag(set_tags[w]);
      rand_bits(256, blk);
      write_tag(6'd9, way_t'(w), tag_set, set_tags[w]);
      write_block(6'd9, way_t'(w), blk);
    end
    add_fetch(make_paddr(set_tags[2], 6'd9, 3'd0), 1'b1, 1'b1);
    add_fetch(make_paddr(set_tags[0], 6'd9, 3'd5), 1'b1, 1'b1);
    add_fetch(make_paddr(set_tags[3], 6'd9, 3'd7), 1'b1, 1'b1);
    run_fetches();
    wait_drain();
    new_tag(t);
    add_fetch(make_paddr(t, 6'd9, 3'd1), 1'b1, 1'b1);
    run_fetches();
    wait_drain();
    complete_miss();

    test_name = "invalidate";
    write_tag(6'd9, 2'd2, tag_invalidate, '0);
    pa = make_paddr(set_tags[2], 6'd9, 3'd4);
    add_fetch(pa, 1'b1, 1'b1);
    run_fetches();
    wait_drain();
    service_miss(pa);
    add_fetch(pa, 1'b1, 1'b1);
    run_fetches();
    wait_drain();

    test_name = "clear_set";
    write_tag(6'd9, 2'd0, tag_clear_set, '0);
    add_fetch(make_paddr(set_tags[1], 6'd9, 3'd0), 1'b1, 1'b1);
    run_fetches();
    wait_drain();
    complete_miss();

    test_name = "dropped";
    add_fetch(pa_hit, 1'b0, 1'b0);
    run_fetches();
    repeat (4) @(posedge clk_i);
    #1;
    add_fetch(pa_hit, 1'b1, 1'b1);
    run_fetches();
    wait_drain();

    test_name = "squash";
    new_tag(t);
    pa = make_paddr(t, 6'd12, 3'd0);
    add_fetch(pa, 1'b1, 1'b1);
    add_fetch(pa_hit, 1'b1, 1'b0);
    run_fetches();
    wait_drain();
    service_miss(pa);
    add_fetch(pa_hit, 1'b1, 1'b1);
    add_fetch(pa, 1'b1, 1'b1);
    run_fetches();
    wait_drain();

    // ready drops while the miss is still in TL
    test_name = "back_pressure";
    new_tag(t);
    pa = make_paddr(t, 6'd20, 3'd2);
    wait_ready();
    vaddr_v_i = 1'b1;
    vaddr_i = {~pa[31:12], pa[11:0]};
    @(posedge clk_i);
    #1;
    vaddr_v_i = 1'b0;
    ptag_v_i = 1'b1;
    ptag_i = pa[31:12];
    cache_req_ready_i = 1'b0;
    exp_pa.push_back(pa);
    exp_due.push_back(-1);
    @(posedge clk_i);
    #1;
    ptag_v_i = 1'b0;
    repeat (4) begin
      @(negedge clk_i);
      check_flag("request while not ready", 1'b0, cache_req_v_o);
      check_flag("fetch ready while not ready", 1'b0, vaddr_ready_o);
    end
    @(posedge clk_i);
    #1;
    cache_req_ready_i = 1'b1;
    // request is due in the first cycle with ready high
    exp_due[0] = cycle_cnt;
    wait_drain();
    complete_miss();

    repeat (4) @(posedge clk_i);
    #1;
    errors = icache_top_i.icache_ctrl_i.icache_chk_i.fail_cnt + exp_pa.size();
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
